//--- icache_settings.svh
// Cache geometry and prefetch limits shared by the cache RTL and its testbench
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

`define ICACHE_IDX_BITS        7                     // log2 of the line count
`define ICACHE_TAG_BITS        22                    // Address bits 31 to 10
`define ICACHE_LINES           (1 << `ICACHE_IDX_BITS)

// Lines the prefetcher may run ahead of the fetch address
`define ICACHE_PREFETCH_DEPTH  4

`define MEM_TAGS               16                    // Tag 0 means no transaction

`endif

//--- mem_bus_pkg.sv
// Memory bus types, imported by every block that talks to the tagged memory port
`default_nettype none

`include "icache_settings.svh"

package mem_bus_pkg;

  typedef enum logic [1:0] {
    BUS_NONE = 2'h0,                                 // Idle bus
    BUS_LOAD = 2'h1                                  // Read one line
  } bus_command_t;

  typedef logic [$clog2(`MEM_TAGS)-1:0] mem_tag_t;   // Zero means no transaction

  typedef logic [63:0] bus_addr_t;                   // Byte address
  typedef logic [63:0] bus_data_t;                   // One memory word, one cache line

endpackage

`default_nettype wire

//--- icache_pkg.sv
// Cache array and prefetcher types, imported by the cache blocks that need them
`default_nettype none

`include "icache_settings.svh"

package icache_pkg;

  // Address bits 9 to 3 select the line
  typedef logic [`ICACHE_IDX_BITS-1:0] cache_index_t;

  // Address bits 31 to 10 are stored and compared
  typedef logic [`ICACHE_TAG_BITS-1:0] cache_tag_t;

  typedef enum logic [1:0] {
    PF_REDIRECT = 2'h0,                              // Reload at the fetch address
    PF_STREAM   = 2'h1,                              // Issue sequential line requests
    PF_HOLD     = 2'h2                               // Window full, no requests
  } prefetch_state_t;

endpackage

`default_nettype wire

//--- icache_fill_if.sv
// Line fill path from the controller into the cache array, one line per edge
`timescale 1ns/1ps
`default_nettype none

interface icache_fill_if import mem_bus_pkg::*, icache_pkg::*; ();

  logic         write_enable;                        // Store the line on this edge
  cache_index_t write_index;
  cache_tag_t   write_tag;
  bus_data_t    write_data;

  modport source (
    output write_enable, write_index, write_tag, write_data
  );

  modport sink (
    input write_enable, write_index, write_tag, write_data
  );

endinterface

`default_nettype wire

//--- icache_mem.sv
// Direct-mapped instruction line store with a combinational lookup and a fill port
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_mem import mem_bus_pkg::*, icache_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  cache_index_t read_index,
  input  cache_tag_t   read_tag,
  output bus_data_t    read_data,
  output logic         hit,
  icache_fill_if.sink  fill
);

  logic [`ICACHE_LINES-1:0] line_valid;
  cache_tag_t               line_tag  [`ICACHE_LINES];
  bus_data_t                line_data [`ICACHE_LINES];

  // Lookup is purely combinational so a hit returns in the fetch cycle
  assign read_data = line_data[read_index];
  assign hit       = line_valid[read_index] && (line_tag[read_index] == read_tag);

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      line_valid <= '0;                              // Whole cache starts empty
    end
    else if (fill.write_enable)
    begin
      line_valid[fill.write_index] <= 1'b1;
    end
  end

  // Payload arrays, overwritten by every fill
  always_ff @(posedge clock)
  begin
    if (fill.write_enable)
    begin
      line_tag[fill.write_index]  <= fill.write_tag;
      line_data[fill.write_index] <= fill.write_data;
    end
  end

endmodule

`default_nettype wire

//--- prefetch_counter.sv
// Prefetch line address and its distance from the fetch address
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module prefetch_counter import mem_bus_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      load,
  input  logic      advance,
  input  bus_addr_t load_addr,
  input  bus_addr_t fetch_addr,
  output bus_addr_t prefetch_addr,
  output logic      window_full
);

  bus_addr_t   fetch_line;
  bus_addr_t   byte_distance;
  logic [60:0] line_distance;
  logic        behind;

  assign fetch_line    = {fetch_addr[63:3], 3'b000};
  assign byte_distance = prefetch_addr - fetch_line;  // Wraps negative when behind
  assign line_distance = byte_distance[63:3];
  assign behind        = byte_distance[63];

  assign window_full = behind || (line_distance >= `ICACHE_PREFETCH_DEPTH);

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      prefetch_addr <= '0;
    end
    else if (load)
    begin
      prefetch_addr <= {load_addr[63:3], 3'b000};     // Restart on the fetch line
    end
    else if (advance)
    begin
      prefetch_addr <= prefetch_addr + 64'd8;         // Next line
    end
  end

endmodule

`default_nettype wire

//--- prefetch_fsm.sv
// Prefetcher control, choosing between redirect, streaming and holding
`timescale 1ns/1ps
`default_nettype none

module prefetch_fsm import icache_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  logic            stall,
  input  logic            accepted,
  input  logic            lost_fetch,
  input  logic            window_full,
  output logic            load,
  output logic            advance,
  output prefetch_state_t state
);

  prefetch_state_t next_state;

  assign load = (state == PF_REDIRECT);

  // A request accepted at the window edge is not counted, so the address stays in range
  assign advance = (state == PF_STREAM) && accepted && !stall && !window_full;

  always_comb
  begin
    next_state = state;
    case (state)
      PF_REDIRECT:
        next_state = PF_STREAM;                      // Load always completes in one cycle
      PF_STREAM:
      begin
        if (lost_fetch)
          next_state = PF_REDIRECT;
        else if (window_full)
          next_state = PF_HOLD;
      end
      PF_HOLD:
      begin
        if (lost_fetch)
          next_state = PF_REDIRECT;
        else if (!window_full)
          next_state = PF_STREAM;                    // Fetch moved on, window has room
      end
      default:
        next_state = PF_REDIRECT;
    endcase
  end

  always_ff @(posedge clock)
  begin
    if (reset)
      state <= PF_REDIRECT;
    else
      state <= next_state;
  end

endmodule

`default_nettype wire

//--- icache_controller.sv
// Tracks outstanding memory reads by tag, forwards returning data and fills the cache
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_controller import mem_bus_pkg::*, icache_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         stall,
  input  bus_addr_t    proc_addr,
  input  logic         cache_hit,
  input  bus_data_t    cache_data,
  input  bus_addr_t    prefetch_addr,
  input  logic         issuing,
  input  mem_tag_t     mem_response,
  input  mem_tag_t     mem_tag,
  input  bus_data_t    mem_data,
  output bus_data_t    proc_data,
  output logic         proc_valid,
  output logic         accepted,
  output logic         lost_fetch,
  icache_fill_if.source fill
);

  logic [`MEM_TAGS-1:0] table_valid;
  bus_addr_t            table_addr [`MEM_TAGS];       // Line address per tag

  bus_addr_t    proc_line;
  bus_addr_t    return_addr;
  logic         return_valid;
  logic         forward;
  logic         outstanding;
  logic         pending_issue;
  cache_index_t return_index;
  cache_tag_t   return_tag;

  assign proc_line = {proc_addr[63:3], 3'b000};

  assign accepted = issuing && (mem_response != '0) && !stall;

  // Tag 0 carries no data
  assign return_valid = (mem_tag != '0) && table_valid[mem_tag];
  assign return_addr  = table_addr[mem_tag];
  assign forward      = return_valid && (return_addr == proc_line);

  assign proc_data  = forward ? mem_data : cache_data;
  assign proc_valid = forward || cache_hit;

  always_comb
  begin
    outstanding = 1'b0;
    for (int i = 1; i < `MEM_TAGS; i++)
    begin
      if (table_valid[i] && (table_addr[i] == proc_line))
        outstanding = 1'b1;
    end
  end

  // The line being requested right now counts as in flight
  assign pending_issue = issuing && (prefetch_addr == proc_line);

  assign lost_fetch = !cache_hit && !outstanding && !forward && !pending_issue;

  assign return_index = return_addr[`ICACHE_IDX_BITS+2:3];
  assign return_tag   = return_addr[`ICACHE_TAG_BITS+`ICACHE_IDX_BITS+2:`ICACHE_IDX_BITS+3];

  // Every returned line goes into the array, stall or not
  assign fill.write_enable = return_valid;
  assign fill.write_index  = return_index;
  assign fill.write_tag    = return_tag;
  assign fill.write_data   = mem_data;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      table_valid <= '0;
    end
    else
    begin
      if (return_valid)
        table_valid[mem_tag] <= 1'b0;
      if (accepted)
        table_valid[mem_response] <= 1'b1;          // A reused tag wins over its own return
    end
  end

  always_ff @(posedge clock)
  begin
    if (accepted)
      table_addr[mem_response] <= prefetch_addr;
  end

endmodule

`default_nettype wire

//--- icache_top.sv
// Instruction cache front end top level, connecting the processor and the tagged memory port
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_top import mem_bus_pkg::*, icache_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         stall,
  input  bus_addr_t    proc_addr,
  output bus_data_t    proc_data,
  output logic         proc_valid,
  output bus_command_t mem_command,
  output bus_addr_t    mem_addr,
  input  mem_tag_t     mem_response,
  input  mem_tag_t     mem_tag,
  input  bus_data_t    mem_data
);

  icache_fill_if fill_bus ();

  prefetch_state_t state;
  cache_index_t    read_index;
  cache_tag_t      read_tag;
  bus_data_t       cache_data;
  bus_addr_t       prefetch_addr;
  logic            cache_hit;
  logic            issuing;
  logic            accepted;
  logic            lost_fetch;
  logic            window_full;
  logic            load;
  logic            advance;

  assign read_index = proc_addr[`ICACHE_IDX_BITS+2:3];
  assign read_tag   = proc_addr[`ICACHE_TAG_BITS+`ICACHE_IDX_BITS+2:`ICACHE_IDX_BITS+3];

  assign mem_command = (reset || (state == PF_HOLD)) ? BUS_NONE : BUS_LOAD;
  assign mem_addr    = prefetch_addr;
  assign issuing     = (mem_command == BUS_LOAD);

  icache_controller i_icache_controller (
    .clock, .reset, .stall, .proc_addr, .cache_hit, .cache_data, .prefetch_addr,
    .issuing, .mem_response, .mem_tag, .mem_data, .proc_data, .proc_valid,
    .accepted, .lost_fetch, .fill (fill_bus.source)
  );

  prefetch_fsm i_prefetch_fsm (
    .clock, .reset, .stall, .accepted, .lost_fetch, .window_full,
    .load, .advance, .state
  );

  prefetch_counter i_prefetch_counter (
    .clock, .reset, .load, .advance, .load_addr (proc_addr),
    .fetch_addr (proc_addr), .prefetch_addr, .window_full
  );

  icache_mem i_icache_mem (
    .clock, .reset, .read_index, .read_tag, .read_data (cache_data),
    .hit (cache_hit), .fill (fill_bus.sink)
  );

endmodule

`default_nettype wire

//--- tb_imem_model.sv
// Tagged memory model for the cache testbench, answers line loads after a fixed latency
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module tb_imem_model import mem_bus_pkg::*; #(
  parameter int LATENCY = 6                          // Cycles from accept to data
) (
  input  logic         clock,
  input  logic         reset,
  input  logic         stall,
  input  bus_command_t mem_command,
  input  bus_addr_t    mem_addr,
  output mem_tag_t     mem_response,
  output mem_tag_t     mem_tag,
  output bus_data_t    mem_data
);

  mem_tag_t  pipe_tag  [LATENCY];                    // Zero marks an empty slot
  bus_addr_t pipe_addr [LATENCY];
  mem_tag_t  next_tag;
  logic      take;

  function automatic bus_data_t memory_word(input bus_addr_t addr);
    return {~addr[31:0], addr[31:0]};
  endfunction

  assign take = (mem_command == BUS_LOAD) && (mem_response != '0) && !stall;

  initial
  begin
    mem_response = '0;
    mem_tag      = '0;
    mem_data     = '0;
  end

  always @(posedge clock)
  begin
    if (reset)
    begin
      for (int i = 0; i < LATENCY; i++)
        pipe_tag[i] <= '0;
      next_tag <= 1;
    end
    else
    begin
      for (int i = LATENCY - 1; i > 0; i--)
      begin
        pipe_tag[i]  <= pipe_tag[i-1];
        pipe_addr[i] <= pipe_addr[i-1];
      end
      pipe_tag[0]  <= take ? mem_response : '0;
      pipe_addr[0] <= {mem_addr[63:3], 3'b000};
      if (take)
        next_tag <= (next_tag == `MEM_TAGS - 1) ? 1 : next_tag + 1;  // Tags 1 to 15 in turn
    end
  end

  // Outputs change on the falling edge, away from the sampling edge
  always @(negedge clock)
  begin
    mem_response <= next_tag;
    mem_tag      <= pipe_tag[LATENCY-1];
    mem_data     <= (pipe_tag[LATENCY-1] != '0) ? memory_word(pipe_addr[LATENCY-1]) : '0;
  end

endmodule

`default_nettype wire

//--- tb_icache_top.sv
// Self-checking testbench for the instruction cache, applies a table of fetch sequences
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module tb_icache_top import mem_bus_pkg::*; ();

  localparam int FETCH_LIMIT = 40;                   // Cycles allowed per fetch
  localparam int MAX_TESTS   = 8;
  localparam int WINDOW      = `ICACHE_PREFETCH_DEPTH * 8;

  logic         clock;
  logic         reset;
  logic         stall;
  bus_addr_t    proc_addr;
  bus_data_t    proc_data;
  logic         proc_valid;
  bus_command_t mem_command;
  bus_addr_t    mem_addr;
  mem_tag_t     mem_response;
  mem_tag_t     mem_tag;
  bus_data_t    mem_data;

  string     test_name  [MAX_TESTS];
  bus_addr_t test_start [MAX_TESTS];
  int        test_count [MAX_TESTS];
  logic      test_stall [MAX_TESTS];                 // Random stall in every cycle
  logic      test_sweep [MAX_TESTS];                 // Lines already filled, expect hits
  int        num_tests;
  int        watchdog_cycles;
  int        total_errors;
  int        failed_tests;
  integer    seed;

  icache_top i_icache_top (
    .clock, .reset, .stall, .proc_addr, .proc_data, .proc_valid,
    .mem_command, .mem_addr, .mem_response, .mem_tag, .mem_data
  );

  tb_imem_model i_imem_model (
    .clock, .reset, .stall, .mem_command, .mem_addr, .mem_response, .mem_tag, .mem_data
  );

  initial clock = 1'b0;
  always #4 clock = ~clock;                          // 8 ns period

  function automatic bus_data_t expected_word(input bus_addr_t addr);
    return {~addr[31:0], addr[31:0]};
  endfunction

  task automatic add_entry(input string name, input bus_addr_t start, input int count,
                           input logic random_stall, input logic sweep);
    test_name[num_tests]  = name;
    test_start[num_tests] = start;
    test_count[num_tests] = count;
    test_stall[num_tests] = random_stall;
    test_sweep[num_tests] = sweep;
    num_tests++;
  endtask

  task automatic report_test(input string name, input int errors);
    $display("%-12s finished with %0d errors", name, errors);
    total_errors += errors;
    if (errors != 0)
      failed_tests++;
  endtask

  task automatic check_reset();
    int errors;
    errors = 0;
    for (int c = 0; c < 4; c++)
    begin
      @(posedge clock);
      if (mem_command !== BUS_NONE)
      begin
        errors++;
        $display("ERROR reset cycle %0d: expected mem_command %0d actual %0d", c, BUS_NONE,
                 mem_command);
      end
      if (c > 0 && proc_valid !== 1'b0)              // Array valid bits clear on the first edge
      begin
        errors++;
        $display("ERROR reset cycle %0d: expected proc_valid 0 actual %b", c, proc_valid);
      end
    end
    @(negedge clock);
    reset     = 1'b0;
    proc_addr = test_start[0];
    repeat (5)
    begin
      @(posedge clock);
      if (proc_valid !== 1'b0)                       // No data can have returned yet
      begin
        errors++;
        $display("ERROR reset: expected proc_valid 0 before data actual %b", proc_valid);
      end
    end
    report_test("reset", errors);
  endtask

  task automatic run_entry(input int e);
    bus_addr_t addr;
    bus_data_t expected;
    integer    rand_value;
    int        errors;
    int        waited;
    logic      seen;
    errors = 0;
    for (int f = 0; f < test_count[e]; f++)
    begin
      addr     = test_start[e] + 8 * f;
      expected = expected_word(addr);
      waited   = 0;
      seen     = 1'b0;
      while (!seen && waited < FETCH_LIMIT)
      begin
        @(negedge clock);
        rand_value = $random(seed);
        proc_addr  = addr;
        stall      = test_stall[e] && rand_value[0];
        @(posedge clock);
        waited++;
        seen = (proc_valid === 1'b1);
        // After the first fetch the prefetcher streams from this sequence
        if (f > 0 && mem_command == BUS_LOAD && mem_addr > addr + WINDOW)
        begin
          errors++;
          $display("ERROR %s fetch %0d: expected mem_addr at most %h actual %h",
                   test_name[e], f, addr + WINDOW, mem_addr);
        end
      end
      if (!seen)
      begin
        errors++;
        $display("%s fetch %0d: no valid data for address %h within %0d cycles",
                 test_name[e], f, addr, FETCH_LIMIT);
      end
      else if (proc_data !== expected)
      begin
        errors++;
        $display("ERROR %s fetch %0d: expected %h actual %h", test_name[e], f, expected,
                 proc_data);
      end
      if (seen && test_sweep[e] && waited != 1)
      begin
        errors++;
        $display("ERROR %s fetch %0d: expected hit latency 1 actual %0d cycles",
                 test_name[e], f, waited);
      end
    end
    report_test(test_name[e], errors);
  endtask

  initial
  begin
    int fetches;
    reset     = 1'b1;
    stall     = 1'b0;
    proc_addr = '0;
    seed      = 32'h0157_b4d0;
    fetches   = 0;
    add_entry("stream",      64'h0000_1000, 16, 1'b0, 1'b0);
    add_entry("sweep",       64'h0000_1000, 16, 1'b0, 1'b1);
    add_entry("redirect",    64'h0004_0200,  8, 1'b0, 1'b0);
    add_entry("stall",       64'h0000_2500, 24, 1'b1, 1'b0);
    add_entry("stall_sweep", 64'h0000_2500, 24, 1'b1, 1'b1);
    add_entry("jump_back",   64'h0000_1800,  8, 1'b0, 1'b0);
    for (int e = 0; e < num_tests; e++)
      fetches += test_count[e];
    watchdog_cycles = fetches * FETCH_LIMIT + 100;
    check_reset();
    for (int e = 0; e < num_tests; e++)
      run_entry(e);
    $display("Tests run %0d, tests with errors %0d, total errors %0d", num_tests + 1,
             failed_tests, total_errors);
    if (total_errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  initial
  begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clock);
    $display("Watchdog expired after %0d cycles, the run did not complete", watchdog_cycles);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- icache_top.f
+incdir+.
mem_bus_pkg.sv
icache_pkg.sv
icache_fill_if.sv
icache_mem.sv
prefetch_counter.sv
prefetch_fsm.sv
icache_controller.sv
icache_top.sv
tb_imem_model.sv
tb_icache_top.sv
